// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_load   = 7'b0000011,
        opc_op_imm = 7'b0010011,
        opc_store  = 7'b0100011,
        opc_op     = 7'b0110011,
        opc_lui    = 7'b0110111,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    // add must stay zero so a cleared control word is a bubble
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_pass_b = 3'd6
    } alu_op_e;

    typedef enum logic {
        op1_pc  = 1'b0,
        op1_rs1 = 1'b1
    } op1_sel_e;

    typedef enum logic [2:0] {
        op2_rs2   = 3'd0,
        op2_imm_i = 3'd1,
        op2_imm_s = 3'd2,
        op2_imm_b = 3'd3,
        op2_imm_u = 3'd4,
        op2_imm_j = 3'd5
    } op2_sel_e;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_pc4  = 2'd1,
        wb_load = 2'd2
    } wb_sel_e;

    // fwd_none keeps the register or immediate value
    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_exe  = 2'd1,
        fwd_mem  = 2'd2,
        fwd_wb   = 2'd3
    } fwd_sel_e;

    // per-instruction control carried down the pipe, all zero is a bubble
    typedef struct packed {
        alu_op_e   alu_op;
        wb_sel_e   wb_sel;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      is_beq;
        logic      is_bne;
        logic      is_jump;
        reg_addr_t rd;
    } ctrl_t;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    typedef struct packed {
        word_t pc;
        word_t instruction;
    } fetch_t;

    // rs2 carries store data and the branch compare operand
    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t op1;
        word_t op2;
        word_t rs2;
    } decode_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t result;
        word_t store_data;
    } execute_t;

endpackage

`default_nettype wire

// File: src/rv_fetch.sv
`default_nettype none

module rv_fetch #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::word_t  instruction,
    input  logic           stall,
    input  logic           kill,
    input  logic           redirect,
    input  rv_pkg::word_t  target,
    output rv_pkg::word_t  pc,
    output rv_pkg::fetch_t fetch_q
);

    rv_pkg::word_t pc_next;

    // a redirect from execute wins over a load-use hold
    always_comb begin
        if (redirect) begin
            pc_next = target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // killed fetches enter decode as a nop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_q.pc          <= reset_pc;
            fetch_q.instruction <= rv_pkg::nop_instr;
        end else if (kill) begin
            fetch_q.instruction <= rv_pkg::nop_instr;
        end else if (!stall) begin
            fetch_q.pc          <= pc;
            fetch_q.instruction <= instruction;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_decoder.sv
`default_nettype none

module rv_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::fetch_t    fetch_q,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::fwd_sel_e  fwd_op1,
    input  rv_pkg::fwd_sel_e  fwd_op2,
    input  rv_pkg::fwd_sel_e  fwd_rs2,
    input  rv_pkg::word_t     exe_result,
    input  rv_pkg::word_t     mem_result,
    input  rv_pkg::word_t     wb_result,
    input  logic              stall,
    input  logic              kill,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    output logic              uses_rs1,
    output logic              uses_rs2,
    output rv_pkg::decode_t   decode_q
);

    rv_pkg::word_t    instr;
    rv_pkg::opcode_e  opcode;
    logic [2:0]       funct3;
    rv_pkg::ctrl_t    ctrl;
    rv_pkg::op1_sel_e op1_sel;
    rv_pkg::op2_sel_e op2_sel;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    op1;
    rv_pkg::word_t    op2;
    rv_pkg::word_t    store_data;

    // newest in-flight value for a source, or the value from decode
    function automatic rv_pkg::word_t fwd_pick(
        input rv_pkg::fwd_sel_e sel,
        input rv_pkg::word_t    base,
        input rv_pkg::word_t    exe_v,
        input rv_pkg::word_t    mem_v,
        input rv_pkg::word_t    wb_v
    );
        case (sel)
            rv_pkg::fwd_exe: return exe_v;
            rv_pkg::fwd_mem: return mem_v;
            rv_pkg::fwd_wb:  return wb_v;
            default:         return base;
        endcase
    endfunction

    assign instr    = fetch_q.instruction;
    assign opcode   = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // unsupported encodings fall out as bubbles
    always_comb begin
        ctrl     = '0;
        ctrl.rd  = instr[11:7];
        op1_sel  = rv_pkg::op1_rs1;
        op2_sel  = rv_pkg::op2_rs2;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            rv_pkg::opc_op: begin
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = instr[30] ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b010:  ctrl.alu_op = rv_pkg::alu_slt;
                    3'b100:  ctrl.alu_op = rv_pkg::alu_xor;
                    3'b110:  ctrl.alu_op = rv_pkg::alu_or;
                    3'b111:  ctrl.alu_op = rv_pkg::alu_and;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            rv_pkg::opc_op_imm: begin
                // only addi is kept
                uses_rs1       = 1'b1;
                op2_sel        = rv_pkg::op2_imm_i;
                ctrl.reg_write = (funct3 == 3'b000);
            end
            rv_pkg::opc_lui: begin
                op2_sel        = rv_pkg::op2_imm_u;
                ctrl.alu_op    = rv_pkg::alu_pass_b;
                ctrl.reg_write = 1'b1;
            end
            rv_pkg::opc_load: begin
                uses_rs1       = 1'b1;
                op2_sel        = rv_pkg::op2_imm_i;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_load;
            end
            rv_pkg::opc_store: begin
                uses_rs1       = 1'b1;
                uses_rs2       = 1'b1;
                op2_sel        = rv_pkg::op2_imm_s;
                ctrl.mem_write = 1'b1;
            end
            rv_pkg::opc_branch: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                op2_sel     = rv_pkg::op2_imm_b;
                ctrl.is_beq = (funct3 == 3'b000);
                ctrl.is_bne = (funct3 == 3'b001);
            end
            rv_pkg::opc_jal: begin
                op1_sel        = rv_pkg::op1_pc;
                op2_sel        = rv_pkg::op2_imm_j;
                ctrl.is_jump   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = rv_pkg::wb_pc4;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (op2_sel)
            rv_pkg::op2_imm_i: imm = {{20{instr[31]}}, instr[31:20]};
            rv_pkg::op2_imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rv_pkg::op2_imm_b: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rv_pkg::op2_imm_u: imm = {instr[31:12], 12'b0};
            rv_pkg::op2_imm_j: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default:           imm = '0;
        endcase
    end

    always_comb begin
        op1 = fetch_q.pc;
        if (op1_sel == rv_pkg::op1_rs1) begin
            op1 = fwd_pick(fwd_op1, rs1_data, exe_result, mem_result, wb_result);
        end
        op2 = imm;
        if (op2_sel == rv_pkg::op2_rs2) begin
            op2 = fwd_pick(fwd_op2, rs2_data, exe_result, mem_result, wb_result);
        end
        store_data = fwd_pick(fwd_rs2, rs2_data, exe_result, mem_result, wb_result);
    end

    // bubble into execute on a kill or a load-use hold
    always_ff @(posedge clk) begin
        decode_q.pc  <= fetch_q.pc;
        decode_q.op1 <= op1;
        decode_q.op2 <= op2;
        decode_q.rs2 <= store_data;
        if (!rst_n || kill || stall) begin
            decode_q.ctrl <= '0;
        end else begin
            decode_q.ctrl <= ctrl;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::reg_addr_t debug_reg,
    input  logic              wr_en,
    input  rv_pkg::word_t     wr_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     debug_data
);

    // x0 has no storage
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write is seen by the decode reads
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (wr_en && wr_addr == rs1_addr) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (wr_en && wr_addr == rs2_addr) begin
            rs2_data = wr_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

    assign debug_data = (debug_reg == '0) ? '0 : regs[debug_reg];

endmodule

`default_nettype wire

// File: src/rv_hazard_unit.sv
`default_nettype none

module rv_hazard_unit (
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  logic              uses_rs1,
    input  logic              uses_rs2,
    input  rv_pkg::ctrl_t     exe_ctrl,
    input  rv_pkg::ctrl_t     mem_ctrl,
    input  rv_pkg::ctrl_t     wb_ctrl,
    input  logic              redirect,
    output rv_pkg::fwd_sel_e  fwd_op1,
    output rv_pkg::fwd_sel_e  fwd_op2,
    output rv_pkg::fwd_sel_e  fwd_rs2,
    output logic              stall,
    output logic              kill
);

    logic load_hit;

    function automatic logic writes_to(input rv_pkg::ctrl_t c, input rv_pkg::reg_addr_t src);
        return c.reg_write && (c.rd != '0) && (c.rd == src);
    endfunction

    // youngest writer first
    function automatic rv_pkg::fwd_sel_e youngest(
        input rv_pkg::reg_addr_t src,
        input rv_pkg::ctrl_t     e,
        input rv_pkg::ctrl_t     m,
        input rv_pkg::ctrl_t     w
    );
        if (writes_to(e, src)) begin
            return rv_pkg::fwd_exe;
        end else if (writes_to(m, src)) begin
            return rv_pkg::fwd_mem;
        end else if (writes_to(w, src)) begin
            return rv_pkg::fwd_wb;
        end
        return rv_pkg::fwd_none;
    endfunction

    assign fwd_op1 = uses_rs1 ? youngest(rs1_addr, exe_ctrl, mem_ctrl, wb_ctrl) : rv_pkg::fwd_none;
    assign fwd_op2 = uses_rs2 ? youngest(rs2_addr, exe_ctrl, mem_ctrl, wb_ctrl) : rv_pkg::fwd_none;

    // store data and branch compare, ignored by decode when rs2 is not read
    assign fwd_rs2 = youngest(rs2_addr, exe_ctrl, mem_ctrl, wb_ctrl);

    // load data only exists one stage later
    assign load_hit = exe_ctrl.mem_read &&
                      ((uses_rs1 && writes_to(exe_ctrl, rs1_addr)) ||
                       (uses_rs2 && writes_to(exe_ctrl, rs2_addr)));

    // a redirect squashes the dependent instruction anyway
    assign stall = load_hit && !redirect;
    assign kill  = redirect;

endmodule

`default_nettype wire

// File: src/rv_execute.sv
`default_nettype none

module rv_execute (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::decode_t  decode_q,
    output rv_pkg::ctrl_t    exe_ctrl,
    output rv_pkg::word_t    exe_result,
    output logic             redirect,
    output rv_pkg::word_t    target,
    output rv_pkg::execute_t execute_q
);

    rv_pkg::word_t alu_out;
    logic          equal;

    assign exe_ctrl = decode_q.ctrl;

    always_comb begin
        case (decode_q.ctrl.alu_op)
            rv_pkg::alu_add: alu_out = decode_q.op1 + decode_q.op2;
            rv_pkg::alu_sub: alu_out = decode_q.op1 - decode_q.op2;
            rv_pkg::alu_and: alu_out = decode_q.op1 & decode_q.op2;
            rv_pkg::alu_or:  alu_out = decode_q.op1 | decode_q.op2;
            rv_pkg::alu_xor: alu_out = decode_q.op1 ^ decode_q.op2;
            rv_pkg::alu_slt: begin
                alu_out = {31'b0, $signed(decode_q.op1) < $signed(decode_q.op2)};
            end
            default:         alu_out = decode_q.op2;
        endcase
    end

    // op1 holds rs1 for branches, op2 holds the offset
    assign equal    = (decode_q.op1 == decode_q.rs2);
    assign redirect = decode_q.ctrl.is_jump ||
                      (decode_q.ctrl.is_beq && equal) ||
                      (decode_q.ctrl.is_bne && !equal);
    assign target   = decode_q.pc + decode_q.op2;

    // jal links pc+4
    assign exe_result = (decode_q.ctrl.wb_sel == rv_pkg::wb_pc4) ? decode_q.pc + 32'd4 : alu_out;

    always_ff @(posedge clk) begin
        execute_q.result     <= exe_result;
        execute_q.store_data <= decode_q.rs2;
        if (!rst_n) begin
            execute_q.ctrl <= '0;
        end else begin
            execute_q.ctrl <= decode_q.ctrl;
        end
    end

endmodule

`default_nettype wire

// File: src/rv_mem_wb.sv
`default_nettype none

module rv_mem_wb (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::execute_t  execute_q,
    input  rv_pkg::word_t     mem_rdata,
    output rv_pkg::word_t     mem_addr,
    output rv_pkg::word_t     mem_wdata,
    output logic              mem_read,
    output logic              mem_write,
    output rv_pkg::ctrl_t     mem_ctrl,
    output rv_pkg::ctrl_t     wb_ctrl,
    output rv_pkg::word_t     mem_result,
    output rv_pkg::word_t     wb_result,
    output logic              wr_en,
    output rv_pkg::reg_addr_t wr_addr
);

    assign mem_ctrl  = execute_q.ctrl;
    assign mem_addr  = execute_q.result;
    assign mem_wdata = execute_q.store_data;
    assign mem_read  = execute_q.ctrl.mem_read;
    assign mem_write = execute_q.ctrl.mem_write;

    // RAM answers in the same cycle
    assign mem_result = (execute_q.ctrl.wb_sel == rv_pkg::wb_load) ? mem_rdata
                                                                   : execute_q.result;

    always_ff @(posedge clk) begin
        wb_result <= mem_result;
        if (!rst_n) begin
            wb_ctrl <= '0;
        end else begin
            wb_ctrl <= execute_q.ctrl;
        end
    end

    assign wr_en   = wb_ctrl.reg_write;
    assign wr_addr = wb_ctrl.rd;

endmodule

`default_nettype wire

// File: src/rv_core.sv
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    output rv_pkg::word_t     pc,
    input  rv_pkg::word_t     instruction,
    output rv_pkg::word_t     mem_addr,
    output logic              mem_read,
    output logic              mem_write,
    output rv_pkg::word_t     mem_wdata,
    input  rv_pkg::word_t     mem_rdata,
    input  rv_pkg::reg_addr_t debug_reg,
    output rv_pkg::word_t     debug_data
);

    rv_pkg::fetch_t    fetch_q;
    rv_pkg::decode_t   decode_q;
    rv_pkg::execute_t  execute_q;

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    logic              uses_rs1;
    logic              uses_rs2;

    rv_pkg::fwd_sel_e  fwd_op1;
    rv_pkg::fwd_sel_e  fwd_op2;
    rv_pkg::fwd_sel_e  fwd_rs2;
    logic              stall;
    logic              kill;
    logic              redirect;
    rv_pkg::word_t     target;

    rv_pkg::ctrl_t     exe_ctrl;
    rv_pkg::ctrl_t     mem_ctrl;
    rv_pkg::ctrl_t     wb_ctrl;
    rv_pkg::word_t     exe_result;
    rv_pkg::word_t     mem_result;
    rv_pkg::word_t     wb_result;
    logic              wr_en;
    rv_pkg::reg_addr_t wr_addr;

    rv_fetch #(
        .reset_pc(reset_pc)
    ) fetch_i (
        .clk(clk),
        .rst_n(rst_n),
        .instruction(instruction),
        .stall(stall),
        .kill(kill),
        .redirect(redirect),
        .target(target),
        .pc(pc),
        .fetch_q(fetch_q)
    );

    rv_decoder decoder_i (
        .clk(clk),
        .rst_n(rst_n),
        .fetch_q(fetch_q),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .fwd_op1(fwd_op1),
        .fwd_op2(fwd_op2),
        .fwd_rs2(fwd_rs2),
        .exe_result(exe_result),
        .mem_result(mem_result),
        .wb_result(wb_result),
        .stall(stall),
        .kill(kill),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .decode_q(decode_q)
    );

    rv_regfile regfile_i (
        .clk(clk),
        .rst_n(rst_n),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .wr_addr(wr_addr),
        .debug_reg(debug_reg),
        .wr_en(wr_en),
        .wr_data(wb_result),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .debug_data(debug_data)
    );

    rv_hazard_unit hazard_i (
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .uses_rs1(uses_rs1),
        .uses_rs2(uses_rs2),
        .exe_ctrl(exe_ctrl),
        .mem_ctrl(mem_ctrl),
        .wb_ctrl(wb_ctrl),
        .redirect(redirect),
        .fwd_op1(fwd_op1),
        .fwd_op2(fwd_op2),
        .fwd_rs2(fwd_rs2),
        .stall(stall),
        .kill(kill)
    );

    rv_execute execute_i (
        .clk(clk),
        .rst_n(rst_n),
        .decode_q(decode_q),
        .exe_ctrl(exe_ctrl),
        .exe_result(exe_result),
        .redirect(redirect),
        .target(target),
        .execute_q(execute_q)
    );

    rv_mem_wb mem_wb_i (
        .clk(clk),
        .rst_n(rst_n),
        .execute_q(execute_q),
        .mem_rdata(mem_rdata),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_ctrl(mem_ctrl),
        .wb_ctrl(wb_ctrl),
        .mem_result(mem_result),
        .wb_result(wb_result),
        .wr_en(wr_en),
        .wr_addr(wr_addr)
    );

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter realtime period = 4ns
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// File: bench/rv_core_properties.sv
`default_nettype none

module rv_core_properties #(
    parameter rv_pkg::word_t poison_addr = 32'h0000_03f0
) (
    input logic          clk,
    input logic          rst_n,
    input rv_pkg::word_t pc,
    input rv_pkg::word_t mem_addr,
    input logic          mem_read,
    input logic          mem_write
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench summary
    int fail_count;

    initial begin
        fail_count = 0;
    end

    read_write_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read && mem_write)
    ) else begin
        fail_count++;
        $error("memory read and write are high in the same cycle");
    end

    pc_word_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("pc is not word aligned");
    end

    // covers every reset cycle and the first cycle after release
    no_write_in_reset: assert property (
        @(posedge clk) !rst_n |=> !mem_write
    ) else begin
        fail_count++;
        $error("memory write during or just after reset");
    end

    poison_never_written: assert property (
        @(posedge clk) disable iff (!rst_n) mem_write |-> mem_addr != poison_addr
    ) else begin
        fail_count++;
        $error("a store reached the poison address");
    end

endmodule

bind rv_core rv_core_properties props_i (
    .clk(clk),
    .rst_n(rst_n),
    .pc(pc),
    .mem_addr(mem_addr),
    .mem_read(mem_read),
    .mem_write(mem_write)
);

`default_nettype wire

// File: bench/tb_top.sv
`default_nettype none

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam rv_pkg::word_t poison_addr = 32'h0000_03f0;
    localparam rv_pkg::word_t load_addr   = 32'h0000_0040;
    localparam rv_pkg::word_t loop_pc     = 32'h0000_0078;
    localparam int            wait_limit  = 200;
    localparam int            num_tests   = 6;

    typedef struct packed {
        logic [2:0]    test;
        rv_pkg::word_t addr;
        rv_pkg::word_t data;
    } store_t;

    logic              clk;
    logic              rst_n;
    rv_pkg::word_t     pc;
    rv_pkg::word_t     instruction;
    rv_pkg::word_t     mem_addr;
    logic              mem_read;
    logic              mem_write;
    rv_pkg::word_t     mem_wdata;
    rv_pkg::word_t     mem_rdata;
    rv_pkg::reg_addr_t debug_reg;
    rv_pkg::word_t     debug_data;

    rv_pkg::word_t rom [0:63];
    rv_pkg::word_t ram [0:255];
    // register values the program should leave behind
    rv_pkg::word_t xreg [0:12];
    store_t        expected [$];
    string         test_name [0:num_tests-1];
    int            test_errors [0:num_tests-1];
    int            store_end [0:4];
    int            stores_done;
    int            loads_seen;
    int            stray_stores;
    int            tests_run;
    int            tests_failed;
    logic          timed_out;

    tb_clock clock_i (
        .clk(clk)
    );

    rv_core #(
        .reset_pc(32'h0000_0000)
    ) rv_core_i (
        .clk(clk),
        .rst_n(rst_n),
        .pc(pc),
        .instruction(instruction),
        .mem_addr(mem_addr),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .debug_reg(debug_reg),
        .debug_data(debug_data)
    );

    // both memories answer in the same cycle
    assign instruction = rom[pc[7:2]];
    assign mem_rdata   = ram[mem_addr[9:2]];

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [6:0] opc, input int rd,
                                            input int rs1, input int imm);
        return {12'(imm), 5'(rs1), (opc == 7'b0000011) ? 3'b010 : 3'b000, 5'(rd), opc};
    endfunction

    function automatic rv_pkg::word_t enc_s(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input int rs1,
                                            input int rs2, input int imm);
        logic [12:0] i;
        i = 13'(imm);
        return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic rv_pkg::word_t enc_j(input int rd, input int imm);
        logic [20:0] i;
        i = 21'(imm);
        return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic load_program();
        int a;
        for (a = 0; a < 64; a++) begin
            rom[a] = 32'h0000_0013;
        end
        // dependent chain, every source comes from a different stage
        rom[0] = enc_i(7'b0010011, 1, 0, 1234);
        rom[1] = enc_i(7'b0010011, 2, 1, -2000);
        rom[2] = enc_r(7'h00, 3'b000, 3, 1, 2);
        rom[3] = enc_r(7'h20, 3'b000, 4, 3, 1);
        rom[4] = enc_r(7'h00, 3'b111, 5, 4, 3);
        rom[5] = enc_r(7'h00, 3'b110, 6, 5, 2);
        rom[6] = enc_r(7'h00, 3'b100, 7, 6, 4);
        rom[7] = enc_r(7'h00, 3'b010, 8, 2, 1);
        rom[8] = {20'habcde, 5'd9, 7'b0110111};
        for (a = 1; a <= 9; a++) begin
            rom[8 + a] = enc_s(a, 0, 32'h100 + 4 * (a - 1));
        end
        // load-use pair
        rom[18] = enc_i(7'b0000011, 10, 0, load_addr);
        rom[19] = enc_r(7'h00, 3'b000, 11, 10, 1);
        rom[20] = enc_s(11, 0, 32'h130);
        // taken beq skips the poison stores, not-taken bne falls through
        rom[21] = enc_b(3'b000, 1, 1, 12);
        rom[22] = enc_s(1, 0, poison_addr);
        rom[23] = enc_s(2, 0, poison_addr);
        rom[24] = enc_b(3'b001, 1, 1, 8);
        rom[25] = enc_s(3, 0, 32'h134);
        rom[26] = enc_j(12, 12);
        rom[27] = enc_s(1, 0, poison_addr);
        rom[28] = enc_s(2, 0, poison_addr);
        rom[29] = enc_s(12, 0, 32'h138);
        rom[30] = enc_j(0, 0);
    endtask

    task automatic build_expected();
        int r;
        xreg[0]  = '0;
        xreg[1]  = 32'd1234;
        xreg[2]  = xreg[1] - 32'd2000;
        xreg[3]  = xreg[1] + xreg[2];
        xreg[4]  = xreg[3] - xreg[1];
        xreg[5]  = xreg[4] & xreg[3];
        xreg[6]  = xreg[5] | xreg[2];
        xreg[7]  = xreg[6] ^ xreg[4];
        xreg[8]  = ($signed(xreg[2]) < $signed(xreg[1])) ? 32'd1 : 32'd0;
        xreg[9]  = 32'habcd_e000;
        xreg[10] = ram[load_addr[9:2]];
        xreg[11] = xreg[10] + xreg[1];
        xreg[12] = 32'h0000_006c;
        for (r = 1; r <= 9; r++) begin
            expected.push_back('{3'd1, 32'h100 + 4 * (r - 1), xreg[r]});
        end
        expected.push_back('{3'd2, 32'h130, xreg[11]});
        expected.push_back('{3'd3, 32'h134, xreg[3]});
        expected.push_back('{3'd4, 32'h138, xreg[12]});
    endtask

    // RAM write port, load and store checks
    always @(negedge clk) begin
        store_t e;
        if (rst_n) begin
            if (stores_done == 0) begin
                assert (!mem_read) else begin
                    test_errors[0]++;
                    $display("memory read before the first store");
                end
            end
            if (mem_read) begin
                loads_seen++;
                assert (mem_addr == load_addr) else begin
                    test_errors[2]++;
                    $display("ERROR %s: load address expected %h, actual %h",
                             test_name[2], load_addr, mem_addr);
                end
            end
            if (mem_write && expected.size() == 0) begin
                stray_stores++;
                $display("store to %h with no store left to expect", mem_addr);
            end else if (mem_write) begin
                e = expected.pop_front();
                assert (mem_addr == e.addr) else begin
                    test_errors[e.test]++;
                    $display("ERROR %s: address expected %h, actual %h",
                             test_name[e.test], e.addr, mem_addr);
                end
                assert (mem_wdata == e.data) else begin
                    test_errors[e.test]++;
                    $display("ERROR %s: data expected %h, actual %h",
                             test_name[e.test], e.data, mem_wdata);
                end
                ram[mem_addr[9:2]] = mem_wdata;
                stores_done++;
            end
        end
    end

    task automatic wait_for_stores(input int count);
        int cycles;
        cycles = 0;
        while (stores_done < count && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (stores_done < count) begin
            timed_out = 1'b1;
            $display("timeout: %0d of %0d stores seen after %0d cycles",
                     stores_done, count, cycles);
        end
    endtask

    // second visit proves the final jal loops
    task automatic wait_for_loop();
        int cycles;
        int visits;
        cycles = 0;
        visits = 0;
        while (visits < 2 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
            if (pc == loop_pc) begin
                visits++;
            end
        end
        if (visits < 2) begin
            timed_out = 1'b1;
            $display("timeout: pc did not settle in the final loop");
        end
    endtask

    task automatic check_debug();
        int r;
        for (r = 1; r <= 7; r++) begin
            debug_reg = 5'(r);
            @(negedge clk);
            assert (debug_data == xreg[r]) else begin
                test_errors[5]++;
                $display("ERROR %s: x%0d expected %h, actual %h",
                         test_name[5], r, xreg[r], debug_data);
            end
        end
    endtask

    task automatic report_test(input int t);
        tests_run++;
        if (test_errors[t] == 0) begin
            $display("test %s: ok", test_name[t]);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name[t], test_errors[t]);
        end
    endtask

    task automatic finish_run();
        int prop_fails;
        prop_fails = rv_core_i.props_i.fail_count;
        $display("tests run %0d, passed %0d, failed %0d, assertion failures %0d, stray stores %0d",
                 tests_run, tests_run - tests_failed, tests_failed, prop_fails, stray_stores);
        if (tests_run == num_tests && tests_failed == 0 && prop_fails == 0 &&
            stray_stores == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        int t;
        int i;
        rst_n        = 1'b0;
        debug_reg    = '0;
        stores_done  = 0;
        loads_seen   = 0;
        stray_stores = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        test_name    = '{"reset", "forwarding", "load_use", "branch", "jal", "debug"};
        store_end    = '{1, 9, 10, 11, 12};
        for (t = 0; t < num_tests; t++) begin
            test_errors[t] = 0;
        end
        void'($urandom(32'h649c_d670));
        for (i = 0; i < 256; i++) begin
            ram[i] = $urandom;
        end
        load_program();
        build_expected();

        // eight reset edges, enables checked after each one
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            @(negedge clk);
            assert (!mem_read && !mem_write) else begin
                test_errors[0]++;
                $display("memory enable high while in reset");
            end
        end
        assert (pc == 32'h0) else begin
            test_errors[0]++;
            $display("ERROR %s: pc expected %h, actual %h", test_name[0], 32'h0, pc);
        end
        rst_n = 1'b1;

        for (t = 0; t < 5 && !timed_out; t++) begin
            wait_for_stores(store_end[t]);
            if (!timed_out) begin
                if (t == 2) begin
                    assert (loads_seen == 1) else begin
                        test_errors[2]++;
                        $display("ERROR %s: loads expected %0d, actual %0d",
                                 test_name[2], 1, loads_seen);
                    end
                end
                report_test(t);
            end
        end
        if (!timed_out) begin
            wait_for_loop();
        end
        if (!timed_out) begin
            check_debug();
            report_test(5);
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: tb.f
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_hazard_unit.sv
src/rv_execute.sv
src/rv_mem_wb.sv
src/rv_core.sv
bench/tb_clock.sv
bench/rv_core_properties.sv
bench/tb_top.sv
